//--- bank_pkg.sv
/*
  bank_pkg
  widths, bank count and request/data types for the banked scratchpad
*/
package bank_pkg;

  localparam int unsigned ADDR_WIDTH  = 16;
  localparam int unsigned DATA_WIDTH  = 64;  // front word, power of two
  localparam int unsigned NUM_BANKS   = 4;
  localparam int unsigned BANK_WIDTH  = DATA_WIDTH / NUM_BANKS;
  localparam int unsigned BANK_BYTES  = BANK_WIDTH / 8;
  localparam int unsigned DATA_BYTES  = DATA_WIDTH / 8;
  localparam int unsigned BANK_DEPTH  = 256;  // words per bank

  // byte offset bits inside one front word, and bank word index width
  localparam int unsigned WORD_OFFSET = $clog2(DATA_BYTES);
  localparam int unsigned BANK_AW     = $clog2(BANK_DEPTH);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [DATA_BYTES-1:0] strb_t;
  typedef logic [BANK_WIDTH-1:0] bank_data_t;
  typedef logic [BANK_BYTES-1:0] bank_strb_t;

  // front request, as presented by the master
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  // one bank's share of a front request
  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

endpackage

//--- bank_req_split.sv
/*
  bank_req_split
  aligns the front address, slices the word into one request per bank and
  holds each until its bank grants; front grant needs every slot free
*/
module bank_req_split import bank_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  mem_req_t                   mem_req_i,
  output logic                       gnt_o,
  input  logic      [NUM_BANKS-1:0]  resp_ready_i,
  output logic      [NUM_BANKS-1:0]  bank_req_o,
  input  logic      [NUM_BANKS-1:0]  bank_gnt_i,
  output bank_req_t [NUM_BANKS-1:0]  bank_req_data_o
);

  logic                       req_valid;
  logic      [NUM_BANKS-1:0]  req_ready;
  bank_req_t [NUM_BANKS-1:0]  bank_req_in;
  addr_t                      aligned_addr;

  // round down to the start of the front word
  assign aligned_addr = {mem_req_i.addr[ADDR_WIDTH-1:WORD_OFFSET], {WORD_OFFSET{1'b0}}};

  // only accept when no bank slot or response slot could overflow
  assign gnt_o     = (&req_ready) & (&resp_ready_i);
  assign req_valid = req_i & gnt_o;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank_req
    assign bank_req_in[i].addr  = aligned_addr + addr_t'(i * BANK_BYTES);
    assign bank_req_in[i].wdata = mem_req_i.wdata[i*BANK_WIDTH +: BANK_WIDTH];
    assign bank_req_in[i].strb  = mem_req_i.strb[i*BANK_BYTES +: BANK_BYTES];
    assign bank_req_in[i].we    = mem_req_i.we;

    fall_through_reg #(
      .T (bank_req_t)
    ) u_req_reg (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (req_valid),
      .ready_o (req_ready[i]),
      .data_i  (bank_req_in[i]),
      .valid_o (bank_req_o[i]),
      .ready_i (bank_gnt_i[i]),
      .data_o  (bank_req_data_o[i])
    );
  end

endmodule

//--- bank_resp_join.sv
/*
  bank_resp_join
  buffers each bank's response slice and releases the joined wide word in
  the cycle the last slice shows up
*/
module bank_resp_join import bank_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic       [NUM_BANKS-1:0]  bank_rvalid_i,
  input  bank_data_t [NUM_BANKS-1:0]  bank_rdata_i,
  output logic       [NUM_BANKS-1:0]  resp_ready_o,
  output logic                        rvalid_o,
  output data_t                       rdata_o
);

  logic       [NUM_BANKS-1:0] slot_valid;
  bank_data_t [NUM_BANKS-1:0] slot_data;

  // nothing downstream stalls, so the join drains every slot at once
  assign rvalid_o = &slot_valid;
  assign rdata_o  = slot_data;  // bank 0 in the low slice

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_resp_reg
    fall_through_reg #(
      .T (bank_data_t)
    ) u_resp_reg (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (bank_rvalid_i[i]),
      .ready_o (resp_ready_o[i]),
      .data_i  (bank_rdata_i[i]),
      .valid_o (slot_valid[i]),
      .ready_i (rvalid_o),
      .data_o  (slot_data[i])
    );
  end

endmodule

//--- bank_sram.sv
/*
  bank_sram
  one byte-strobed single-port bank; grants unless stalled from outside and
  returns the (possibly updated) word one cycle after a completed request
*/
module bank_sram import bank_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       stall_i,     // conflict with another master
  input  logic       req_i,
  input  bank_req_t  req_data_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output bank_data_t rdata_o
);

  bank_data_t         mem_q [BANK_DEPTH];
  logic [BANK_AW-1:0] word_idx;
  bank_data_t         cur_word;
  bank_data_t         new_word;
  logic               fire;

  assign gnt_o    = ~stall_i;
  assign fire     = req_i & gnt_o;

  // bits below WORD_OFFSET select bank and byte, above that the bank word
  assign word_idx = req_data_i.addr[WORD_OFFSET +: BANK_AW];
  assign cur_word = mem_q[word_idx];

  // merge strobed bytes over the stored word
  always_comb begin
    new_word = cur_word;
    for (int b = 0; b < BANK_BYTES; b++) begin
      if (req_data_i.strb[b]) begin
        new_word[8*b +: 8] = req_data_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire && req_data_i.we) begin
      mem_q[word_idx] <= new_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      rdata_o <= req_data_i.we ? new_word : cur_word;  // write returns updated word
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= fire;
    end
  end

endmodule

//--- banked_mem_assert.sv
/*
  banked_mem_assert
  request splitter checks: held bank requests, reset state, front grant
*/
module banked_mem_assert import bank_pkg::*; (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      gnt_i,
  input logic      [NUM_BANKS-1:0] bank_req_i,
  input logic      [NUM_BANKS-1:0] bank_gnt_i,
  input bank_req_t [NUM_BANKS-1:0] bank_req_data_i
);

  typedef bank_req_t [NUM_BANKS-1:0] req_vec_t;

  logic [NUM_BANKS-1:0] waiting;  // requesting but not granted
  int unsigned          hold_fails  = 0;
  int unsigned          reset_fails = 0;
  int unsigned          gnt_fails   = 0;
  int unsigned          fail_cnt;

  assign waiting  = bank_req_i & ~bank_gnt_i;
  assign fail_cnt = hold_fails + reset_fails + gnt_fails;

  // payloads of the masked banks, the rest zeroed
  function automatic req_vec_t held_part(req_vec_t d, logic [NUM_BANKS-1:0] m);
    req_vec_t r;
    r = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (m[i]) begin
        r[i] = d[i];
      end
    end
    return r;
  endfunction

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    waiting != '0 |=> ((bank_req_i & $past(waiting)) == $past(waiting)) &&
      (held_part(bank_req_data_i, $past(waiting)) ==
       held_part($past(bank_req_data_i), $past(waiting))))
    else begin
      $error("ungranted bank request dropped or changed");
      hold_fails++;
    end

  a_reset: assert property (@(posedge clk_i) !rst_n_i |=> bank_req_i == '0)
    else begin
      $error("bank request active right after reset");
      reset_fails++;
    end

  // an ungranted bank request leaves its register full and blocks the front grant
  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    waiting != '0 |=> !gnt_i)
    else begin
      $error("front grant while a bank request register is full");
      gnt_fails++;
    end

endmodule

bind bank_req_split banked_mem_assert u_assert (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .gnt_i           (gnt_o),
  .bank_req_i      (bank_req_o),
  .bank_gnt_i      (bank_gnt_i),
  .bank_req_data_i (bank_req_data_o)
);

//--- banked_mem_top.sv
/*
  banked_mem_top
  banked scratchpad: splitter, NUM_BANKS bank memories and response joiner
*/
module banked_mem_top import bank_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  mem_req_t              mem_req_i,
  output logic                  gnt_o,
  input  logic [NUM_BANKS-1:0]  bank_stall_i,
  output logic                  rvalid_o,
  output data_t                 rdata_o
);

  logic       [NUM_BANKS-1:0] bank_req;
  logic       [NUM_BANKS-1:0] bank_gnt;
  bank_req_t  [NUM_BANKS-1:0] bank_req_data;
  logic       [NUM_BANKS-1:0] bank_rvalid;
  bank_data_t [NUM_BANKS-1:0] bank_rdata;
  logic       [NUM_BANKS-1:0] resp_ready;  // joiner slots free

  bank_req_split u_split (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .mem_req_i       (mem_req_i),
    .gnt_o           (gnt_o),
    .resp_ready_i    (resp_ready),
    .bank_req_o      (bank_req),
    .bank_gnt_i      (bank_gnt),
    .bank_req_data_o (bank_req_data)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    bank_sram u_bank (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .stall_i    (bank_stall_i[i]),
      .req_i      (bank_req[i]),
      .req_data_i (bank_req_data[i]),
      .gnt_o      (bank_gnt[i]),
      .rvalid_o   (bank_rvalid[i]),
      .rdata_o    (bank_rdata[i])
    );
  end

  bank_resp_join u_join (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .resp_ready_o  (resp_ready),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o)
  );

endmodule

//--- fall_through_reg.sv
/*
  fall_through_reg
  one-entry buffer: an empty slot passes the input straight through,
  a full slot holds its payload until the consumer takes it
*/
module fall_through_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  logic load;   // input arrives but consumer is not taking it
  T     data_q;

  assign load    = ~full_q & valid_i & ~ready_i;

  assign ready_o = ~full_q;
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;  // bypass while empty

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (ready_i) begin
        full_q <= 1'b0;  // stored entry taken
      end
    end else if (load) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

//--- sim.f
bank_pkg.sv
fall_through_reg.sv
bank_req_split.sv
bank_sram.sv
bank_resp_join.sv
banked_mem_top.sv
banked_mem_assert.sv
tb_banked_mem.sv

//--- tb_banked_mem.sv
/*
  tb_banked_mem
  drives the banked scratchpad with directed and random traffic, random bank
  stalls, and checks every response against a byte-level reference memory
*/
module tb_banked_mem import bank_pkg::*; ();

  localparam int unsigned MEM_BYTES   = DATA_BYTES * BANK_DEPTH;
  localparam int unsigned FILL_REQS   = BANK_DEPTH;
  localparam int unsigned DIR_WORDS   = 8;
  localparam int unsigned UNALIGN_CNT = 4;
  localparam int unsigned RAND_REQS   = 400;
  localparam int unsigned TOTAL_REQS  = FILL_REQS + 4 * DIR_WORDS + 2 * UNALIGN_CNT + RAND_REQS;
  localparam int unsigned TIMEOUT     = TOTAL_REQS * 40 + 400;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  mem_req_t             mem_req;
  logic                 gnt;
  logic [NUM_BANKS-1:0] bank_stall;
  logic                 rvalid;
  data_t                rdata;

  logic                 stall_en;  // random bank stalls on/off
  logic [7:0]           ref_mem [MEM_BYTES];
  data_t                exp_q [$];
  int unsigned          err_cnt  = 0;
  int unsigned          acc_cnt  = 0;
  int unsigned          resp_cnt = 0;

  banked_mem_top u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .mem_req_i    (mem_req),
    .gnt_o        (gnt),
    .bank_stall_i (bank_stall),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata)
  );

  // applies one request to the byte model and returns the word it should answer
  function automatic data_t ref_access(mem_req_t r);
    int unsigned base;
    data_t       word;
    base = (r.addr % MEM_BYTES) / DATA_BYTES * DATA_BYTES;  // word containing the byte
    for (int k = 0; k < DATA_BYTES; k++) begin
      if (r.we && r.strb[k]) begin
        ref_mem[base + k] = r.wdata[8*k +: 8];
      end
      word[8*k +: 8] = ref_mem[base + k];
    end
    return word;
  endfunction

  function automatic data_t fill_word(addr_t a);
    return {a ^ 16'hc3a5, ~a, a + 16'h1357, a};
  endfunction

  // holds the request until granted; handshake completes at the next rising edge
  task automatic issue(input addr_t addr, input data_t wdata, input strb_t strb,
                       input logic we);
    mem_req_t r;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    r.we    = we;
    @(posedge clk);
    req     <= 1'b1;
    mem_req <= r;
    @(negedge clk);
    while (!gnt) begin
      @(negedge clk);
    end
    exp_q.push_back(ref_access(r));
    acc_cnt++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req <= 1'b0;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  initial begin : stall_gen
    forever begin
      @(posedge clk);
      for (int i = 0; i < NUM_BANKS; i++) begin
        bank_stall[i] <= stall_en && ($urandom_range(0, 3) == 0);  // about one in four
      end
    end
  end

  initial begin : compare
    data_t exp;
    forever begin
      @(negedge clk);
      if (rvalid) begin
        resp_cnt++;
        if (exp_q.size() == 0) begin
          $display("[ERROR] %0t: response with no request outstanding", $time);
          err_cnt++;
        end else begin
          exp = exp_q.pop_front();
          if (rdata !== exp) begin
            $display("[ERROR] %0t: rdata %h, expected %h", $time, rdata, exp);
            err_cnt++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("watchdog expired: responses missing, %0d of %0d arrived", resp_cnt, acc_cnt);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    addr_t       a;
    strb_t       s;
    int unsigned total_err;
    void'($urandom(93177));
    rst_n      = 1'b0;
    req        = 1'b0;
    mem_req    = '0;
    bank_stall = '0;
    stall_en   = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // quiet after reset, front port ready
    repeat (3) begin
      @(negedge clk);
      if (rvalid !== 1'b0) begin
        $display("[ERROR] %0t: rvalid_o high after reset", $time);
        err_cnt++;
      end
      if (gnt !== 1'b1) begin
        $display("[ERROR] %0t: gnt_o low after reset with no stall", $time);
        err_cnt++;
      end
    end

    for (int w = 0; w < FILL_REQS; w++) begin
      a = addr_t'(w * DATA_BYTES);
      issue(a, fill_word(a), '1, 1'b1);
    end

    // full-strobe write, then read back
    for (int n = 0; n < DIR_WORDS; n++) begin
      a = addr_t'($urandom_range(0, BANK_DEPTH - 1) * DATA_BYTES);
      issue(a, {$urandom, $urandom}, '1, 1'b1);
      issue(a, '0, '0, 1'b0);
    end

    // partial strobes leave the other bytes alone
    for (int n = 0; n < DIR_WORDS; n++) begin
      a = addr_t'($urandom_range(0, BANK_DEPTH - 1) * DATA_BYTES);
      s = strb_t'($urandom_range(1, 254));
      issue(a, {$urandom, $urandom}, s, 1'b1);
      issue(a, '0, '0, 1'b0);
    end

    // unaligned byte addresses hit the containing word
    for (int n = 0; n < UNALIGN_CNT; n++) begin
      a = addr_t'($urandom_range(0, BANK_DEPTH - 1) * DATA_BYTES);
      issue(a + addr_t'($urandom_range(1, DATA_BYTES - 1)), {$urandom, $urandom}, '1, 1'b1);
      issue(a + addr_t'($urandom_range(1, DATA_BYTES - 1)), '0, '0, 1'b0);
    end

    stall_en = 1'b1;
    for (int n = 0; n < RAND_REQS; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        idle_cycle();
      end
      issue(addr_t'($urandom_range(0, MEM_BYTES - 1)), {$urandom, $urandom},
            strb_t'($urandom), logic'($urandom_range(0, 1)));
    end
    stall_en = 1'b0;
    idle_cycle();

    wait (resp_cnt == acc_cnt);
    repeat (4) @(negedge clk);  // catch stray responses

    if (resp_cnt != acc_cnt) begin
      $display("response count %0d does not match accepted requests %0d", resp_cnt, acc_cnt);
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      err_cnt++;
    end

    total_err = err_cnt + u_dut.u_split.u_assert.fail_cnt;
    $display("errors: %0d (checks %0d, assertions %0d), accepted %0d, responses %0d",
             total_err, err_cnt, u_dut.u_split.u_assert.fail_cnt, acc_cnt, resp_cnt);
    if (total_err == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
